// File: black_line_gen.sv
// Black line generator for one masked pipe
// FSM emitting FS, long header, zero data beats and FE
`include "mask_defines.svh"

module black_line_gen (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  en,
    input  logic [1:0]            vc,
    input  logic [5:0]            dt,
    input  logic [15:0]           wc,
    input  logic [15:0]           fcnt,
    output logic                  req,
    input  logic                  grant,
    output logic                  line_end,
    output logic                  beat_valid,
    input  logic                  beat_ready,
    output idi_pkg::idi_payload_u payload,
    output logic [`IDI_BE_W-1:0]  byte_en,
    output logic                  hdr_flag,
    output logic                  ftr_flag,
    output logic                  short_flag,
    output logic                  data_flag
);

    // ========================================================================
    // State encoding
    // ========================================================================
    localparam logic [2:0] IDLE       = 3'd0;
    localparam logic [2:0] WAIT_GRANT = 3'd1;
    localparam logic [2:0] FS         = 3'd2;
    localparam logic [2:0] HEADER     = 3'd3;
    localparam logic [2:0] DATA       = 3'd4;
    localparam logic [2:0] FE         = 3'd5;

    logic [2:0]           state;
    logic [11:0]          cnt;       // Data beat index
    logic [11:0]          last_idx;  // ceil(wc/16) - 1
    logic [`IDI_BE_W-1:0] last_be;
    logic [1:0]           lat_vc;
    logic [5:0]           lat_dt;
    logic [15:0]          lat_wc;
    logic [15:0]          lat_fnum;
    logic                 last_beat;
    logic                 fire;      // Beat accepted

    assign fire      = beat_valid & beat_ready;
    assign last_beat = (cnt == last_idx);

    // ========================================================================
    // FSM and beat counter
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                IDLE:       if (en) state <= WAIT_GRANT;  // One idle cycle between lines
                WAIT_GRANT: begin
                    // Request held until granted
                    if (grant) begin
                        state <= FS;
                        cnt   <= '0;
                    end
                end
                FS:         if (fire) state <= HEADER;
                HEADER:     if (fire) state <= DATA;
                DATA: begin
                    if (fire) begin
                        cnt <= cnt + 12'd1;
                        if (last_beat)
                            state <= FE;
                    end
                end
                FE:         if (fire) state <= IDLE;
                default:    state <= IDLE;
            endcase
        end
    end

    // Line snapshot, stable for the whole line
    always_ff @(posedge clk) begin
        if (state == WAIT_GRANT && grant) begin
            lat_vc   <= vc;
            lat_dt   <= dt;
            lat_wc   <= wc;
            lat_fnum <= fcnt;
            last_idx <= 12'((wc - 16'd1) >> 4);
            // Low (wc mod 16) bytes, full beat when it divides evenly
            last_be  <= (wc[3:0] == 4'd0) ? '1 : (`IDI_BE_W'(1) << wc[3:0]) - `IDI_BE_W'(1);
        end
    end

    // ========================================================================
    // Beat outputs, decoded from state
    // ========================================================================
    assign req        = (state == WAIT_GRANT);
    assign beat_valid = (state == FS) || (state == HEADER) || (state == DATA) || (state == FE);
    assign line_end   = (state == FE) && beat_ready;  // FE accepted
    assign hdr_flag   = (state == FS) || (state == HEADER) || (state == FE);
    assign short_flag = (state == FS) || (state == FE);
    assign data_flag  = (state == DATA);
    assign ftr_flag   = (state == DATA) && last_beat;

    always_comb begin
        payload = '0;
        byte_en = '0;
        case (state)
            FS, FE: begin
                payload.hdr.vc = lat_vc;
                payload.hdr.dt = (state == FS) ? idi_pkg::DT_FS : idi_pkg::DT_FE;
                payload.hdr.wf = lat_fnum;  // Frame number
            end
            HEADER: begin
                payload.hdr.vc = lat_vc;
                payload.hdr.dt = lat_dt;
                payload.hdr.wf = lat_wc;
            end
            DATA: begin
                payload.px = '0;  // Black pixels
                byte_en    = last_beat ? last_be : '1;
            end
            default: ;
        endcase
    end

    // ========================================================================
    // Checks
    // ========================================================================
    // Stalled beat must not change under the scheduler
    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        beat_valid && !beat_ready |=> beat_valid && $stable(payload) && $stable(byte_en)
        && $stable({hdr_flag, ftr_flag, short_flag, data_flag}));

    a_grant_req: assert property (@(posedge clk) disable iff (!rst_n)
        grant |-> req);

    // Zero-length lines are not supported by the register setup
    a_wc_nz: assert property (@(posedge clk) disable iff (!rst_n)
        grant |-> wc != 16'd0);

endmodule

// File: idi_pkg.sv
// IDI beat payload union and packet datatype constants
`include "mask_defines.svh"

package idi_pkg;

    // Short packet datatypes
    localparam logic [5:0] DT_FS = 6'h00;  // Frame start
    localparam logic [5:0] DT_FE = 6'h01;  // Frame end

    // ========================================================================
    // Beat payload, one word with two readings
    // ========================================================================
    // Header view for FS, FE and the long packet header.
    // wf is the word count of a long header, the frame number of FS/FE
    typedef union packed {
        struct packed {
            logic [`IDI_PAYLOAD_W-25:0] rsvd;  // Always zero
            logic [15:0]                wf;
            logic [5:0]                 dt;
            logic [1:0]                 vc;    // Low bits of the beat
        } hdr;
        logic [`IDI_BE_W-1:0][7:0] px;         // Byte 0 in bits 7:0
    } idi_payload_u;

endpackage

// File: line_sched.sv
// Round-robin line scheduler
// Grants one pipe per line and muxes its beats to the output port
`include "mask_defines.svh"

module line_sched (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [`MASK_NUM_PIPES-1:0]               req,
    output logic [`MASK_NUM_PIPES-1:0]               grant,
    input  logic [`MASK_NUM_PIPES-1:0]               line_end,
    input  logic [`MASK_NUM_PIPES-1:0]               beat_valid,
    output logic [`MASK_NUM_PIPES-1:0]               beat_ready,
    input  idi_pkg::idi_payload_u [`MASK_NUM_PIPES-1:0] payloads,
    input  logic [`MASK_NUM_PIPES-1:0][`IDI_BE_W-1:0] byte_ens,
    input  logic [`MASK_NUM_PIPES-1:0]               hdr_flags,
    input  logic [`MASK_NUM_PIPES-1:0]               ftr_flags,
    input  logic [`MASK_NUM_PIPES-1:0]               short_flags,
    input  logic [`MASK_NUM_PIPES-1:0]               data_flags,
    output logic                                     out_valid,
    input  logic                                     out_ready,
    output idi_pkg::idi_payload_u                    out_payload,
    output logic [`IDI_BE_W-1:0]                     out_byte_en,
    output logic                                     out_hdr,
    output logic                                     out_ftr,
    output logic                                     out_short,
    output logic                                     out_data
);

    localparam int N  = `MASK_NUM_PIPES;
    localparam int IW = (N > 1) ? $clog2(N) : 1;

    logic          busy;   // A line is in flight
    logic [IW-1:0] owner;  // Pipe holding the output
    logic [IW-1:0] ptr;    // Last pipe that finished a line
    logic [IW-1:0] pick;
    logic [IW-1:0] cand;
    logic          found;

    // First requester after ptr, wrapping
    always_comb begin
        found = 1'b0;
        pick  = ptr;
        cand  = ptr;
        for (int k = 1; k <= N; k++) begin
            cand = IW'((int'(ptr) + k) % N);
            if (!found && req[cand]) begin
                found = 1'b1;
                pick  = cand;
            end
        end
    end

    // ========================================================================
    // Grant and ownership
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy  <= 1'b0;
            owner <= '0;
            ptr   <= IW'(N - 1);  // Pipe 0 goes first
            grant <= '0;
        end else begin
            grant <= '0;  // Single-cycle pulse
            if (busy) begin
                if (line_end[owner]) begin
                    busy <= 1'b0;
                    ptr  <= owner;
                end
            end else if (found) begin
                busy  <= 1'b1;
                owner <= pick;
                grant <= N'(1) << pick;
            end
        end
    end

    // Output mux, owner's beat straight through
    always_comb begin
        beat_ready        = '0;
        beat_ready[owner] = busy & out_ready;
        out_valid         = busy & beat_valid[owner];
        out_payload       = payloads[owner];
        out_byte_en       = byte_ens[owner];
        out_hdr           = hdr_flags[owner];
        out_ftr           = ftr_flags[owner];
        out_short         = short_flags[owner];
        out_data          = data_flags[owner];
    end

    a_grant_1hot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(grant));

endmodule

// File: mask_cfg_pkg.sv
// Register map of the Wishbone slave
// Offsets and configuration word fields
`include "mask_defines.svh"

package mask_cfg_pkg;

    // Per-pipe banks, pipe i at base + 4*i
    localparam logic [`MASK_WB_AW-1:0] REG_CFG_BASE  = 'h00;  // Read/write
    localparam logic [`MASK_WB_AW-1:0] REG_FCNT_BASE = 'h20;  // Read only

    // Configuration word
    localparam int CFG_WC_LSB = 0;   // Word count, 16 bits
    localparam int CFG_DT_LSB = 16;  // Datatype, 6 bits
    localparam int CFG_VC_LSB = 24;  // Virtual channel, 2 bits
    localparam int CFG_EN_BIT = 31;  // Pipe enable

endpackage

// File: mask_defines.svh
// Global sizes for the masked video output block
// Pipe count, Wishbone bus widths, IDI beat widths
`ifndef MASK_DEFINES_SVH
`define MASK_DEFINES_SVH

// Number of black line generator pipes
`define MASK_NUM_PIPES 4

// Wishbone classic slave
`define MASK_WB_AW 8    // Byte address
`define MASK_WB_DW 32

// IDI beat
`define IDI_PAYLOAD_W 128
`define IDI_BE_W      16  // One enable per payload byte

`endif

// File: mask_pipes.f
+incdir+.
idi_pkg.sv
mask_cfg_pkg.sv
mask_wb_regs.sv
black_line_gen.sv
line_sched.sv
mask_pipes_top.sv
tb_clkgen.sv
mask_pipes_tb.sv

// File: mask_pipes_tb.sv
// Testbench for the masked video output block
// Stimulus table, Wishbone tasks, beat monitor, ready LCG and watchdog
`include "mask_defines.svh"

module mask_pipes_tb;

    localparam int NP        = `MASK_NUM_PIPES;
    localparam int ROWS      = 8;
    localparam int SOLO_ROWS = 4;   // Rows 0..3 run alone, the rest together
    localparam int CLK_T     = 40;

    logic                   clk;
    logic                   rst_n;
    logic                   wb_cyc, wb_stb, wb_we;
    logic [`MASK_WB_AW-1:0] wb_adr;
    logic [`MASK_WB_DW-1:0] wb_dat_w;
    logic [`MASK_WB_DW-1:0] wb_dat_r;
    logic                   wb_ack;
    logic                   out_valid, out_ready;
    idi_pkg::idi_payload_u  out_payload;
    logic [`IDI_BE_W-1:0]   out_byte_en;
    logic                   out_hdr, out_ftr, out_short, out_data;
    wire  [3:0]             out_flags = {out_hdr, out_ftr, out_short, out_data};

    // Stimulus table, one column per field
    int row_pipe [ROWS] = '{0, 1, 2, 3, 0, 1, 2, 3};
    int row_vc   [ROWS] = '{1, 2, 3, 0, 2, 3, 0, 1};    // Distinct per live set
    int row_dt   [ROWS] = '{'h2A, 'h1E, 'h2B, 'h24, 'h2A, 'h2C, 'h12, 'h2D};
    int row_wc   [ROWS] = '{40, 16, 5, 33, 17, 64, 3, 31};

    int exp_vc     [NP];
    int exp_dt     [NP];
    int exp_wc     [NP];
    int lines_seen [NP];       // Complete lines per pipe, also next frame number
    bit live       [NP];       // Pipe may still emit lines
    int mon_pipe;              // Pipe of the line in flight, -1 between lines
    int mon_idx;               // Beat index inside the line
    bit rr_check;
    int rr_prev;
    bit stalled;
    logic [`IDI_PAYLOAD_W+`IDI_BE_W+3:0] held;  // Stalled beat snapshot
    int err_value, err_proto;
    int unsigned lcg_state = 35;

    tb_clkgen #(.PERIOD(CLK_T)) u_clk (.clk);

    mask_pipes_top uut (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .out_valid, .out_ready, .out_payload, .out_byte_en,
        .out_hdr, .out_ftr, .out_short, .out_data
    );

    // ========================================================================
    // Checks and reference model
    // ========================================================================
    task automatic check_payload(input idi_pkg::idi_payload_u got, exp, input string what);
        if (got !== exp) begin
            err_value++;
            $display("[ERROR] %0t: %s payload %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_byte_en(input logic [`IDI_BE_W-1:0] got, exp, input string what);
        if (got !== exp) begin
            err_value++;
            $display("[ERROR] %0t: %s byte_en %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_flags(input logic [3:0] got, exp, input string what);
        if (got !== exp) begin
            err_value++;
            $display("[ERROR] %0t: %s flags hdr/ftr/short/data %b, expected %b",
                     $time, what, got, exp);
        end
    endtask

    task automatic check_word(input logic [`MASK_WB_DW-1:0] got, exp, input string what);
        if (got !== exp) begin
            err_value++;
            $display("[ERROR] %0t: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic report_fault(input string msg);
        err_proto++;
        $display("Protocol fault at time %0t: %s", $time, msg);
    endtask

    function automatic int unsigned lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic logic [31:0] cfg_word(input int r, input logic en);
        logic [31:0] w;
        w = '0;
        w[mask_cfg_pkg::CFG_WC_LSB +: 16] = 16'(row_wc[r]);
        w[mask_cfg_pkg::CFG_DT_LSB +: 6]  = 6'(row_dt[r]);
        w[mask_cfg_pkg::CFG_VC_LSB +: 2]  = 2'(row_vc[r]);
        w[mask_cfg_pkg::CFG_EN_BIT]       = en;
        return w;
    endfunction

    // Live pipe with this vc, -1 if none
    function automatic int find_pipe(input logic [1:0] vc);
        int hit;
        hit = -1;
        for (int p = NP - 1; p >= 0; p--)
            if (live[p] && exp_vc[p] == int'(vc)) hit = p;
        return hit;
    endfunction

    function automatic int next_live(input int prev);
        int nxt;
        nxt = -1;
        for (int k = NP; k >= 1; k--)
            if (live[(prev + k) % NP]) nxt = (prev + k) % NP;
        return nxt;
    endfunction

    // FS, long header, ceil(wc/16) zero data beats, FE
    task automatic build_beat(input int p, input int idx, input int nbeats,
                              output idi_pkg::idi_payload_u pl,
                              output logic [`IDI_BE_W-1:0] be, output logic [3:0] fl);
        int rem;
        pl  = '0;
        be  = '0;
        rem = exp_wc[p] % 16;
        if (idx == 0 || idx == nbeats + 2) begin
            pl.hdr.vc = 2'(exp_vc[p]);
            pl.hdr.dt = (idx == 0) ? idi_pkg::DT_FS : idi_pkg::DT_FE;
            pl.hdr.wf = 16'(lines_seen[p]);   // Frame number
            fl        = 4'b1010;
        end else if (idx == 1) begin
            pl.hdr.vc = 2'(exp_vc[p]);
            pl.hdr.dt = 6'(exp_dt[p]);
            pl.hdr.wf = 16'(exp_wc[p]);
            fl        = 4'b1000;
        end else begin
            for (int b = 0; b < `IDI_BE_W; b++)
                be[b] = (idx < nbeats + 1) || (rem == 0) || (b < rem);
            fl = {1'b0, idx == nbeats + 1, 1'b0, 1'b1};  // Footer on last data beat
        end
    endtask

    task automatic take_beat();
        idi_pkg::idi_payload_u exp_pl;
        logic [`IDI_BE_W-1:0]  exp_be;
        logic [3:0]            exp_fl;
        int                    nbeats;
        string                 tag;
        if (mon_pipe < 0) begin
            mon_pipe = find_pipe(out_payload.hdr.vc);  // Line start
            mon_idx  = 0;
            if (mon_pipe >= 0 && rr_check && rr_prev >= 0 && mon_pipe != next_live(rr_prev))
                report_fault($sformatf("pipe %0d took a turn out of round-robin order",
                                       mon_pipe));
        end
        if (mon_pipe < 0) begin
            report_fault($sformatf("line began on vc %0d with no enabled pipe",
                                   out_payload.hdr.vc));
        end else begin
            nbeats = (exp_wc[mon_pipe] + 15) / 16;
            tag    = $sformatf("pipe %0d beat %0d", mon_pipe, mon_idx);
            build_beat(mon_pipe, mon_idx, nbeats, exp_pl, exp_be, exp_fl);
            check_payload(out_payload, exp_pl, tag);
            check_byte_en(out_byte_en, exp_be, tag);
            check_flags(out_flags, exp_fl, tag);
            if (mon_idx == nbeats + 2) begin
                lines_seen[mon_pipe]++;
                if (rr_check)
                    rr_prev = mon_pipe;
                mon_pipe = -1;
            end else begin
                mon_idx++;
            end
        end
    endtask

    // Sampled mid-cycle, inputs only move 5 after the rising edge
    always @(negedge clk) begin
        if (!rst_n) begin
            stalled = 1'b0;
        end else begin
            if (stalled && !out_valid)
                report_fault("out_valid dropped while a beat was stalled");
            else if (stalled && held !== {out_payload, out_byte_en, out_flags})
                report_fault("output beat changed while stalled");
            if (out_valid && out_ready)
                take_beat();
            stalled = out_valid && !out_ready;
            held    = {out_payload, out_byte_en, out_flags};
        end
    end

    // Random back-pressure, ready about 70 percent
    always @(posedge clk) begin
        #5;
        if (rst_n)
            out_ready = ((lcg_next() >> 16) % 100) < 70;
    end

    // ========================================================================
    // Wishbone access and test sequence
    // ========================================================================
    task automatic wb_access(input logic we, input logic [`MASK_WB_AW-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int lat;
        @(posedge clk);
        #5;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        @(negedge clk);
        if (wb_ack)
            report_fault("wb_ack came in the same cycle as stb");
        lat = 1;
        @(negedge clk);
        while (!wb_ack && lat < 8) begin
            @(negedge clk);
            lat++;
        end
        if (!wb_ack)
            report_fault($sformatf("no wb_ack for address %h", adr));
        else if (lat != 1)
            report_fault($sformatf("wb_ack came %0d cycles after stb", lat));
        rdat = wb_dat_r;
        @(posedge clk);
        #5;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [`MASK_WB_AW-1:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [`MASK_WB_AW-1:0] adr, output logic [31:0] dat);
        wb_access(1'b0, adr, '0, dat);
    endtask

    task automatic configure(input int r, input logic en);
        logic [`MASK_WB_AW-1:0] adr;
        logic [31:0]            rd;
        adr                     = mask_cfg_pkg::REG_CFG_BASE + `MASK_WB_AW'(4 * row_pipe[r]);
        exp_vc[row_pipe[r]]     = row_vc[r];
        exp_dt[row_pipe[r]]     = row_dt[r];
        exp_wc[row_pipe[r]]     = row_wc[r];
        if (en)
            live[row_pipe[r]] = 1'b1;
        wb_write(adr, cfg_word(r, en));
        wb_read(adr, rd);
        check_word(rd, cfg_word(r, en), $sformatf("row %0d config", r));
    endtask

    // Output idle long enough that no granted line is left
    task automatic wait_quiet();
        int quiet;
        quiet = 0;
        while (quiet < 8) begin
            @(negedge clk);
            quiet = out_valid ? 0 : quiet + 1;
        end
    endtask

    task automatic run_solo(input int r);
        int base;
        base = lines_seen[row_pipe[r]];
        configure(r, 1'b1);
        while (lines_seen[row_pipe[r]] < base + 2)  // Two lines, consecutive frames
            @(negedge clk);
        configure(r, 1'b0);
        wait_quiet();
        live[row_pipe[r]] = 1'b0;
    endtask

    task automatic run_group();
        int  base [NP];
        bit  done;
        for (int r = SOLO_ROWS; r < ROWS; r++)
            configure(r, 1'b1);
        for (int p = 0; p < NP; p++)
            base[p] = lines_seen[p];
        rr_prev  = -1;
        rr_check = 1'b1;  // All pipes requesting from here on
        done     = 1'b0;
        while (!done) begin
            @(negedge clk);
            done = 1'b1;
            for (int r = SOLO_ROWS; r < ROWS; r++)
                if (lines_seen[row_pipe[r]] < base[row_pipe[r]] + 3) done = 1'b0;
        end
        rr_check = 1'b0;
        for (int r = SOLO_ROWS; r < ROWS; r++)
            configure(r, 1'b0);
        wait_quiet();
        for (int r = SOLO_ROWS; r < ROWS; r++)
            live[row_pipe[r]] = 1'b0;
    endtask

    task automatic check_registers();
        logic [31:0]            rd;
        logic [`MASK_WB_AW-1:0] unmapped [5] = '{'h02, 'h10, 'h1C, 'h30, 'hFC};
        wb_write(mask_cfg_pkg::REG_FCNT_BASE + `MASK_WB_AW'(4), 32'h0000_BEEF);  // Read only
        for (int p = 0; p < NP; p++) begin
            wb_read(mask_cfg_pkg::REG_FCNT_BASE + `MASK_WB_AW'(4 * p), rd);
            check_word(rd, 32'(lines_seen[p] % 65536), $sformatf("pipe %0d frame count", p));
        end
        for (int i = 0; i < 5; i++) begin
            wb_write(unmapped[i], 32'hFFFF_FFFF);
            wb_read(unmapped[i], rd);
            check_word(rd, '0, $sformatf("unmapped address %h", unmapped[i]));
        end
    endtask

    initial begin
        rst_n     = 1'b0;
        wb_cyc    = 1'b0;
        wb_stb    = 1'b0;
        wb_we     = 1'b0;
        wb_adr    = '0;
        wb_dat_w  = '0;
        out_ready = 1'b0;
        mon_pipe  = -1;
        mon_idx   = 0;
        rr_check  = 1'b0;
        rr_prev   = -1;
        err_value = 0;
        err_proto = 0;
        for (int p = 0; p < NP; p++) begin
            lines_seen[p] = 0;
            live[p]       = 1'b0;
        end
        repeat (16) @(posedge clk);
        #5 rst_n = 1'b1;
        for (int r = 0; r < SOLO_ROWS; r++)
            run_solo(r);
        run_group();
        check_registers();
        $display("Error count: %0d value, %0d protocol", err_value, err_proto);
        if (err_value + err_proto == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // Beats per row x 4 cycles x period, each row good for up to 4 lines
    initial begin : watchdog
        longint limit;
        limit = 32000;   // Reset, register traffic and idle gaps
        for (int r = 0; r < ROWS; r++)
            limit += longint'(((row_wc[r] + 15) / 16 + 3) * 4 * CLK_T * 4);
        #(limit);
        $display("Timeout: tests still running after %0d time units", limit);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: mask_pipes_top.sv
// Masked video output block top level
// Register file, generator pipes and line scheduler
`include "mask_defines.svh"

module mask_pipes_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   wb_cyc,
    input  logic                   wb_stb,
    input  logic                   wb_we,
    input  logic [`MASK_WB_AW-1:0] wb_adr,
    input  logic [`MASK_WB_DW-1:0] wb_dat_w,
    output logic [`MASK_WB_DW-1:0] wb_dat_r,
    output logic                   wb_ack,
    output logic                   out_valid,
    input  logic                   out_ready,
    output idi_pkg::idi_payload_u  out_payload,
    output logic [`IDI_BE_W-1:0]   out_byte_en,
    output logic                   out_hdr,
    output logic                   out_ftr,
    output logic                   out_short,
    output logic                   out_data
);

    // Register file to generators
    logic [`MASK_NUM_PIPES-1:0]                pipe_en;
    logic [`MASK_NUM_PIPES-1:0][1:0]           pipe_vc;
    logic [`MASK_NUM_PIPES-1:0][5:0]           pipe_dt;
    logic [`MASK_NUM_PIPES-1:0][15:0]          pipe_wc;
    logic [`MASK_NUM_PIPES-1:0][15:0]          pipe_fcnt;
    // Generators to scheduler
    logic [`MASK_NUM_PIPES-1:0]                req, grant, line_end;
    logic [`MASK_NUM_PIPES-1:0]                beat_valid, beat_ready;
    idi_pkg::idi_payload_u [`MASK_NUM_PIPES-1:0] payloads;
    logic [`MASK_NUM_PIPES-1:0][`IDI_BE_W-1:0] byte_ens;
    logic [`MASK_NUM_PIPES-1:0]                hdr_flags, ftr_flags;
    logic [`MASK_NUM_PIPES-1:0]                short_flags, data_flags;

    mask_wb_regs u_regs (
        .clk, .rst_n, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
        .line_end, .pipe_en, .pipe_vc, .pipe_dt, .pipe_wc, .pipe_fcnt
    );

    for (genvar g = 0; g < `MASK_NUM_PIPES; g++) begin : g_pipe
        black_line_gen u_gen (
            .clk, .rst_n,
            .en(pipe_en[g]), .vc(pipe_vc[g]), .dt(pipe_dt[g]), .wc(pipe_wc[g]),
            .fcnt(pipe_fcnt[g]),
            .req(req[g]), .grant(grant[g]), .line_end(line_end[g]),
            .beat_valid(beat_valid[g]), .beat_ready(beat_ready[g]),
            .payload(payloads[g]), .byte_en(byte_ens[g]),
            .hdr_flag(hdr_flags[g]), .ftr_flag(ftr_flags[g]),
            .short_flag(short_flags[g]), .data_flag(data_flags[g])
        );
    end

    line_sched u_sched (
        .clk, .rst_n, .req, .grant, .line_end, .beat_valid, .beat_ready,
        .payloads, .byte_ens, .hdr_flags, .ftr_flags, .short_flags, .data_flags,
        .out_valid, .out_ready, .out_payload, .out_byte_en,
        .out_hdr, .out_ftr, .out_short, .out_data
    );

endmodule

// File: mask_wb_regs.sv
// Wishbone classic register file
// Per-pipe configuration words and 16-bit frame counters
`include "mask_defines.svh"

module mask_wb_regs (
    input  logic                                 clk,
    input  logic                                 rst_n,
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [`MASK_WB_AW-1:0]               wb_adr,
    input  logic [`MASK_WB_DW-1:0]               wb_dat_w,
    output logic [`MASK_WB_DW-1:0]               wb_dat_r,
    output logic                                 wb_ack,
    input  logic [`MASK_NUM_PIPES-1:0]           line_end,
    output logic [`MASK_NUM_PIPES-1:0]           pipe_en,
    output logic [`MASK_NUM_PIPES-1:0][1:0]      pipe_vc,
    output logic [`MASK_NUM_PIPES-1:0][5:0]      pipe_dt,
    output logic [`MASK_NUM_PIPES-1:0][15:0]     pipe_wc,
    output logic [`MASK_NUM_PIPES-1:0][15:0]     pipe_fcnt
);

    logic [`MASK_WB_DW-1:0] cfg  [`MASK_NUM_PIPES];
    logic [15:0]            fcnt [`MASK_NUM_PIPES];
    logic [`MASK_WB_DW-1:0] rd_data;
    logic                   access;

    // New cycle seen, ack not yet given
    assign access = wb_cyc & wb_stb & ~wb_ack;

    // ========================================================================
    // Address decode
    // ========================================================================
    always_comb begin
        rd_data = '0;  // Unmapped reads zero
        for (int i = 0; i < `MASK_NUM_PIPES; i++) begin
            if (wb_adr == mask_cfg_pkg::REG_CFG_BASE + `MASK_WB_AW'(4 * i))
                rd_data = cfg[i];
            if (wb_adr == mask_cfg_pkg::REG_FCNT_BASE + `MASK_WB_AW'(4 * i))
                rd_data = {{(`MASK_WB_DW - 16){1'b0}}, fcnt[i]};
        end
    end

    // Single-cycle ack, one cycle after cyc & stb
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb_ack <= 1'b0;
        else
            wb_ack <= access;
    end

    always_ff @(posedge clk) begin
        if (access)
            wb_dat_r <= rd_data;  // Valid during ack
    end

    // Config writes land with the ack
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MASK_NUM_PIPES; i++)
                cfg[i] <= '0;  // All pipes disabled
        end else begin
            for (int i = 0; i < `MASK_NUM_PIPES; i++) begin
                if (access && wb_we &&
                    wb_adr == mask_cfg_pkg::REG_CFG_BASE + `MASK_WB_AW'(4 * i))
                    cfg[i] <= wb_dat_w;
            end
        end
    end

    // Frame counters, one step per finished line, wrap at 16 bits
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `MASK_NUM_PIPES; i++)
                fcnt[i] <= '0;
        end else begin
            for (int i = 0; i < `MASK_NUM_PIPES; i++) begin
                if (line_end[i])
                    fcnt[i] <= fcnt[i] + 16'd1;
            end
        end
    end

    // Field split towards the generators
    always_comb begin
        for (int i = 0; i < `MASK_NUM_PIPES; i++) begin
            pipe_en[i]   = cfg[i][mask_cfg_pkg::CFG_EN_BIT];
            pipe_vc[i]   = cfg[i][mask_cfg_pkg::CFG_VC_LSB +: 2];
            pipe_dt[i]   = cfg[i][mask_cfg_pkg::CFG_DT_LSB +: 6];
            pipe_wc[i]   = cfg[i][mask_cfg_pkg::CFG_WC_LSB +: 16];
            pipe_fcnt[i] = fcnt[i];
        end
    end

    // Ack is a pulse, the master sees one ack per access
    a_ack_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        wb_ack |=> !wb_ack);

endmodule

// File: tb_clkgen.sv
// Testbench clock source
// Free-running clock, period set by parameter
module tb_clkgen #(
    parameter int PERIOD = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;  // 50 percent duty
    end

endmodule
